//--- include/sdram_macros.svh
`ifndef SDRAM_MACROS_SVH
`define SDRAM_MACROS_SVH

// --------------------
// Address split
// --------------------
`define ADDR_W 26
`define ROW_W 14   // Address bits 25..12
`define BANK_W 3   // Address bits 11..9
`define COL_W 9    // Address bits 8..0
`define MASK_W 4

// A10 high selects all banks
`define PRCH_ADDR 14'h0400

// --------------------
// Command spacing
// --------------------
`define CNT_W 4

// Interval counter loads per command
`define LOAD_ARSR 4'h3
`define LOAD_ACTV 4'hC
`define LOAD_RW 4'hB
`define LOAD_NOOP 4'hE

// Start of each two-count end window
`define DONE_NORM 4'hD   // D or E
`define DONE_DLAY 4'hE   // E or F, after a write

// Row-active timer whose top bit marks tRAS passed
`define ACTV_WAIT_W 3

`endif

//--- source/sdram_pkg.sv
`include "sdram_macros.svh"

package sdram_pkg;

  // Pin encoding of {RAS#, CAS#, WE#}
  typedef enum logic [2:0]
  {
    NOOP = 3'b111,
    ACTV = 3'b011,   // Row open
    READ = 3'b101,
    WRTE = 3'b100,
    PRCH = 3'b010,   // Row close
    ARSR = 3'b001    // Auto refresh
  } cmd_e;

  // Row and bank of one page
  typedef struct packed
  {
    logic [`ROW_W-1:0]  row;
    logic [`BANK_W-1:0] bank;
  } page_t;

endpackage

//--- source/port_req_if.sv
`timescale 1ns/1ps

`include "sdram_macros.svh"

interface port_req_if;

  logic               request;   // Registered request level
  logic               we;
  logic [`MASK_W-1:0] mask;
  sdram_pkg::page_t   page;
  logic [`COL_W-1:0]  column;
  logic               hit;       // On open page, nothing else pending
  logic               grant;     // One-cycle pulse with the access

  modport matcher
  (
    output request,
    output we,
    output mask,
    output page,
    output column,
    output hit
  );

  modport scheduler
  (
    input  request,
    input  we,
    input  mask,
    input  page,
    input  column,
    input  hit,
    output grant
  );

endinterface

//--- source/port_page_matcher.sv
`timescale 1ns/1ps

`include "sdram_macros.svh"

module port_page_matcher
(
  input  logic               INPUT_CLK,
  input  logic               RST,
  input  logic [`ADDR_W-1:0] address,
  input  logic               we,
  input  logic               request,
  input  logic [`MASK_W-1:0] mask,
  input  sdram_pkg::page_t   open_page,
  input  logic               page_active,
  input  logic               refresh_due,
  port_req_if.matcher        req
);

  sdram_pkg::page_t live_page;
  logic             live_hit;

  // Row and bank sit above the column bits
  assign live_page = sdram_pkg::page_t'(address[`ADDR_W-1:`COL_W]);

  // A pending refresh must close the row first, so no hit then
  assign live_hit = request &&
                    page_active &&
                    !refresh_due &&
                    (live_page == open_page);

  // --------------------
  // Control
  // --------------------
  always_ff @(posedge INPUT_CLK)
  begin
    if (!RST)
    begin
      req.request <= 1'b0;
      req.hit     <= 1'b0;
    end
    else
    begin
      req.request <= request;
      req.hit     <= live_hit;
    end
  end

  // --------------------
  // Payload
  // --------------------
  always_ff @(posedge INPUT_CLK)
  begin
    req.we     <= we;
    req.mask   <= mask;
    req.page   <= live_page;
    req.column <= address[`COL_W-1:0];
  end

endmodule

//--- source/cmd_spacing_timer.sv
`timescale 1ns/1ps

`include "sdram_macros.svh"

module cmd_spacing_timer
(
  input  logic            INPUT_CLK,
  input  logic            RST,
  input  logic            issue,
  input  sdram_pkg::cmd_e issued_cmd,
  input  logic            hit_any,
  input  logic            last_was_write,
  input  logic            page_active,
  output logic            may_change,
  output logic            row_ready
);

  logic                    post_issue;   // Slot in which the command is on the pins
  logic                    extra_pass;   // Refresh needs one full wrap
  logic                    at_norm;
  logic                    at_dlay;
  logic                    may_change_next;
  logic [`CNT_W-1:0]       counter;
  logic [`CNT_W-1:0]       load_val;
  logic [`ACTV_WAIT_W-1:0] actv_wait;

  assign at_norm = (counter == `DONE_NORM) || (counter == `DONE_NORM + 1'b1);
  assign at_dlay = (counter == `DONE_DLAY) || (counter == `DONE_DLAY + 1'b1);

  assign row_ready = actv_wait[`ACTV_WAIT_W-1];

  always_comb
  begin
    case (issued_cmd)
      sdram_pkg::ARSR: load_val = `LOAD_ARSR;
      sdram_pkg::ACTV: load_val = `LOAD_ACTV;
      sdram_pkg::NOOP: load_val = `LOAD_NOOP;
      default:         load_val = `LOAD_RW;   // READ, WRTE, PRCH
    endcase
  end

  // A precharge after a write waits for write recovery
  always_comb
  begin
    if (post_issue)
      may_change_next = 1'b0;
    else if (hit_any)
      may_change_next = at_norm;
    else if (extra_pass)
      may_change_next = 1'b0;
    else if (page_active && last_was_write)
      may_change_next = at_dlay;
    else
      may_change_next = at_norm;
  end

  always_ff @(posedge INPUT_CLK)
  begin
    if (!RST)
    begin
      post_issue <= 1'b0;
      may_change <= 1'b0;
      counter    <= '1;
      extra_pass <= 1'b1;
      actv_wait  <= '1;
    end
    else
    begin
      post_issue <= issue;
      may_change <= issue ? 1'b0 : may_change_next;

      if (post_issue)
      begin
        counter <= load_val;
        if (issued_cmd == sdram_pkg::ARSR)
          extra_pass <= 1'b1;
      end
      else
      begin
        counter <= counter + {{(`CNT_W-1){1'b0}}, !may_change};   // Freeze once open
        if (counter == '0)
          extra_pass <= 1'b0;
      end

      if (post_issue && (issued_cmd == sdram_pkg::ACTV))
        actv_wait <= '0;
      else if (!row_ready)
        actv_wait <= actv_wait + 1'b1;
    end
  end

endmodule

//--- source/command_scheduler.sv
`timescale 1ns/1ps

`include "sdram_macros.svh"

module command_scheduler
(
  input  logic               INPUT_CLK,
  input  logic               RST,
  input  logic               refresh_strobe,
  port_req_if.scheduler      rand_req,
  port_req_if.scheduler      bulk_req,
  input  logic               may_change,
  input  logic               row_ready,
  output logic               issue,
  output sdram_pkg::cmd_e    issued_cmd,
  output logic               hit_any,
  output logic               last_was_write,
  output sdram_pkg::page_t   open_page,
  output logic               page_active,
  output logic               refresh_due,
  output logic [`ROW_W-1:0]  address_out,
  output logic [`BANK_W-1:0] bank_out,
  output sdram_pkg::cmd_e    command_out,
  output logic [`MASK_W-1:0] we_mask_out
);

  logic               refresh_ack;   // Strobe level at the last ARSR
  logic               bulk_sel;
  logic               acc_we;
  logic [`COL_W-1:0]  acc_col;
  logic [`MASK_W-1:0] acc_mask;
  sdram_pkg::page_t   req_page;
  sdram_pkg::cmd_e    next_cmd;
  logic [`ROW_W-1:0]  next_addr;

  assign hit_any = rand_req.hit || bulk_req.hit;

  // Bulk wins whenever both ports hit
  assign bulk_sel = bulk_req.hit;
  assign acc_we   = bulk_sel ? bulk_req.we : rand_req.we;
  assign acc_col  = bulk_sel ? bulk_req.column : rand_req.column;
  assign acc_mask = bulk_sel ? bulk_req.mask : rand_req.mask;
  assign req_page = bulk_req.request ? bulk_req.page : rand_req.page;

  assign issue      = may_change && (rand_req.request || bulk_req.request || refresh_due);
  assign issued_cmd = command_out;

  // --------------------
  // Command select
  // --------------------
  always_comb
  begin
    if (hit_any)
      next_cmd = acc_we ? sdram_pkg::WRTE : sdram_pkg::READ;
    else if (page_active)
      next_cmd = row_ready ? sdram_pkg::PRCH : sdram_pkg::NOOP;   // Wait out tRAS
    else if (refresh_due)
      next_cmd = sdram_pkg::ARSR;
    else
      next_cmd = sdram_pkg::ACTV;
  end

  always_comb
  begin
    case (next_cmd)
      sdram_pkg::READ,
      sdram_pkg::WRTE: next_addr = {{(`ROW_W-`COL_W-1){1'b0}}, acc_col, 1'b0};
      sdram_pkg::ACTV: next_addr = req_page.row;
      default:         next_addr = `PRCH_ADDR;
    endcase
  end

  // --------------------
  // Control state
  // --------------------
  always_ff @(posedge INPUT_CLK)
  begin
    if (!RST)
    begin
      command_out    <= sdram_pkg::NOOP;
      page_active    <= 1'b0;
      last_was_write <= 1'b0;
      refresh_ack    <= 1'b0;
      refresh_due    <= 1'b0;
      rand_req.grant <= 1'b0;
      bulk_req.grant <= 1'b0;
    end
    else
    begin
      refresh_due    <= refresh_ack ^ refresh_strobe;
      command_out    <= issue ? next_cmd : sdram_pkg::NOOP;
      bulk_req.grant <= issue && bulk_req.hit;
      rand_req.grant <= issue && rand_req.hit && !bulk_req.hit;

      if (issue)
      begin
        if (next_cmd == sdram_pkg::ACTV)
          page_active <= 1'b1;
        if (next_cmd == sdram_pkg::PRCH)
          page_active <= 1'b0;
        if (next_cmd == sdram_pkg::ARSR)
          refresh_ack <= refresh_strobe;
        if (next_cmd == sdram_pkg::WRTE)
          last_was_write <= 1'b1;
        else if (next_cmd != sdram_pkg::NOOP)
          last_was_write <= 1'b0;
      end
    end
  end

  // --------------------
  // Address and mask
  // --------------------
  always_ff @(posedge INPUT_CLK)
  begin
    if (issue)
    begin
      address_out <= next_addr;
      if (next_cmd == sdram_pkg::ACTV)
      begin
        open_page <= req_page;
        bank_out  <= req_page.bank;   // Stays valid for the accesses
      end
      if (hit_any)
        we_mask_out <= acc_mask;
    end
  end

endmodule

//--- source/sdram_cmd_top.sv
`timescale 1ns/1ps

`include "sdram_macros.svh"

module sdram_cmd_top
(
  input  logic               INPUT_CLK,
  input  logic               RST,
  input  logic               refresh_strobe,
  input  logic [`ADDR_W-1:0] rand_address,
  input  logic               rand_we,
  input  logic               rand_request,
  input  logic [`MASK_W-1:0] rand_mask,
  output logic               rand_grant,
  input  logic [`ADDR_W-1:0] bulk_address,
  input  logic               bulk_we,
  input  logic               bulk_request,
  input  logic [`MASK_W-1:0] bulk_mask,
  output logic               bulk_grant,
  output logic [`ROW_W-1:0]  address_out,
  output logic [`BANK_W-1:0] bank_out,
  output sdram_pkg::cmd_e    command_out,
  output logic [`MASK_W-1:0] we_mask_out
);

  logic             issue;
  sdram_pkg::cmd_e  issued_cmd;
  logic             hit_any;
  logic             last_was_write;
  sdram_pkg::page_t open_page;
  logic             page_active;
  logic             refresh_due;
  logic             may_change;
  logic             row_ready;

  port_req_if rand_req ();
  port_req_if bulk_req ();

  assign rand_grant = rand_req.grant;
  assign bulk_grant = bulk_req.grant;

  port_page_matcher u_rand
  (
    .INPUT_CLK   (INPUT_CLK),
    .RST         (RST),
    .address     (rand_address),
    .we          (rand_we),
    .request     (rand_request),
    .mask        (rand_mask),
    .open_page   (open_page),
    .page_active (page_active),
    .refresh_due (refresh_due),
    .req         (rand_req.matcher)
  );

  port_page_matcher u_bulk
  (
    .INPUT_CLK   (INPUT_CLK),
    .RST         (RST),
    .address     (bulk_address),
    .we          (bulk_we),
    .request     (bulk_request),
    .mask        (bulk_mask),
    .open_page   (open_page),
    .page_active (page_active),
    .refresh_due (refresh_due),
    .req         (bulk_req.matcher)
  );

  cmd_spacing_timer u_timer
  (
    .INPUT_CLK      (INPUT_CLK),
    .RST            (RST),
    .issue          (issue),
    .issued_cmd     (issued_cmd),
    .hit_any        (hit_any),
    .last_was_write (last_was_write),
    .page_active    (page_active),
    .may_change     (may_change),
    .row_ready      (row_ready)
  );

  command_scheduler u_sched
  (
    .INPUT_CLK      (INPUT_CLK),
    .RST            (RST),
    .refresh_strobe (refresh_strobe),
    .rand_req       (rand_req.scheduler),
    .bulk_req       (bulk_req.scheduler),
    .may_change     (may_change),
    .row_ready      (row_ready),
    .issue          (issue),
    .issued_cmd     (issued_cmd),
    .hit_any        (hit_any),
    .last_was_write (last_was_write),
    .open_page      (open_page),
    .page_active    (page_active),
    .refresh_due    (refresh_due),
    .address_out    (address_out),
    .bank_out       (bank_out),
    .command_out    (command_out),
    .we_mask_out    (we_mask_out)
  );

endmodule

//--- verification/tb_sdram_cmd.sv
`timescale 1ns/1ps

`include "sdram_macros.svh"

module tb_sdram_cmd;

  localparam logic [2:0]  CMD_NOOP = 3'h7;
  localparam logic [2:0]  CMD_ACTV = 3'h3;
  localparam logic [2:0]  CMD_READ = 3'h5;
  localparam logic [2:0]  CMD_WRTE = 3'h4;
  localparam logic [2:0]  CMD_PRCH = 3'h2;
  localparam logic [2:0]  CMD_ARSR = 3'h1;
  localparam logic [13:0] ALL_BANKS = 14'h0400;
  localparam int MAX_TESTS = 64;
  localparam int CYCLES_PER_TEST = 200;

  typedef struct packed
  {
    logic [2:0]  cmd;
    logic [13:0] addr;
    logic [2:0]  bank;
    logic [3:0]  mask;
    logic [1:0]  port;   // 0 none, 1 rand, 2 bulk
  } expect_t;

  logic               INPUT_CLK;
  logic               RST;
  logic               refresh_strobe;
  logic [`ADDR_W-1:0] rand_address;
  logic               rand_we;
  logic               rand_request;
  logic [`MASK_W-1:0] rand_mask;
  logic               rand_grant;
  logic [`ADDR_W-1:0] bulk_address;
  logic               bulk_we;
  logic               bulk_request;
  logic [`MASK_W-1:0] bulk_mask;
  logic               bulk_grant;
  logic [`ROW_W-1:0]  address_out;
  logic [`BANK_W-1:0] bank_out;
  logic [2:0]         command_out;
  logic [`MASK_W-1:0] we_mask_out;

  string              ev_kind [MAX_TESTS];
  logic               ev_we [MAX_TESTS];
  logic [`ADDR_W-1:0] ev_addr [MAX_TESTS];
  logic [`MASK_W-1:0] ev_mask [MAX_TESTS];
  logic               ev2_we [MAX_TESTS];   // Rand side of a both line
  logic [`ADDR_W-1:0] ev2_addr [MAX_TESTS];
  logic [`MASK_W-1:0] ev2_mask [MAX_TESTS];

  expect_t     exp_q [$];
  logic        model_open;
  logic [16:0] model_page;
  logic [3:0]  held_mask;   // Mask of the last access
  bit          mask_valid;
  int          n_tests;
  int          errors;
  bit          loaded;
  bit          checking;

  sdram_cmd_top i_sdram_cmd_top
  (
    .INPUT_CLK      (INPUT_CLK),
    .RST            (RST),
    .refresh_strobe (refresh_strobe),
    .rand_address   (rand_address),
    .rand_we        (rand_we),
    .rand_request   (rand_request),
    .rand_mask      (rand_mask),
    .rand_grant     (rand_grant),
    .bulk_address   (bulk_address),
    .bulk_we        (bulk_we),
    .bulk_request   (bulk_request),
    .bulk_mask      (bulk_mask),
    .bulk_grant     (bulk_grant),
    .address_out    (address_out),
    .bank_out       (bank_out),
    .command_out    (command_out),
    .we_mask_out    (we_mask_out)
  );

  always #5 INPUT_CLK = ~INPUT_CLK;

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected)
    begin
      $display("ERR %s: got %h, expected %h", name, actual, expected);
      errors++;
    end
  endtask

  // --------------------
  // Reference model
  // --------------------
  task automatic push_cmd(input logic [2:0] cmd, input logic [13:0] addr,
                          input logic [2:0] bank, input logic [3:0] mask,
                          input logic [1:0] port);
    expect_t e;
    e = {cmd, addr, bank, mask, port};
    exp_q.push_back(e);
  endtask

  task automatic serve_port(input logic [1:0] port, input logic we,
                            input logic [`ADDR_W-1:0] addr, input logic [3:0] mask);
    logic [16:0] page;
    page = addr[`ADDR_W-1:`COL_W];
    if (!(model_open && page == model_page))
    begin
      if (model_open)
        push_cmd(CMD_PRCH, ALL_BANKS, model_page[2:0], 4'h0, 2'd0);
      push_cmd(CMD_ACTV, page[16:3], page[2:0], 4'h0, 2'd0);
      model_open = 1'b1;
      model_page = page;
    end
    push_cmd(we ? CMD_WRTE : CMD_READ, {4'h0, addr[8:0], 1'b0}, page[2:0], mask, port);
  endtask

  task automatic predict_event(input int idx);
    logic bulk_hit;
    logic rand_hit;
    bulk_hit = model_open && (ev_addr[idx][`ADDR_W-1:`COL_W] == model_page);
    rand_hit = model_open && (ev2_addr[idx][`ADDR_W-1:`COL_W] == model_page);
    if (ev_kind[idx] == "refresh")
    begin
      if (model_open)
        push_cmd(CMD_PRCH, ALL_BANKS, model_page[2:0], 4'h0, 2'd0);
      push_cmd(CMD_ARSR, ALL_BANKS, 3'h0, 4'h0, 2'd0);
      model_open = 1'b0;
    end
    else if (ev_kind[idx] == "rand")
      serve_port(2'd1, ev_we[idx], ev_addr[idx], ev_mask[idx]);
    else if (ev_kind[idx] == "bulk")
      serve_port(2'd2, ev_we[idx], ev_addr[idx], ev_mask[idx]);
    else if (rand_hit && !bulk_hit)   // Open-page hit goes ahead of bulk
    begin
      serve_port(2'd1, ev2_we[idx], ev2_addr[idx], ev2_mask[idx]);
      serve_port(2'd2, ev_we[idx], ev_addr[idx], ev_mask[idx]);
    end
    else
    begin
      serve_port(2'd2, ev_we[idx], ev_addr[idx], ev_mask[idx]);
      serve_port(2'd1, ev2_we[idx], ev2_addr[idx], ev2_mask[idx]);
    end
  endtask

  // --------------------
  // Stimulus
  // --------------------
  task automatic drive_event(input int idx);
    logic rand_wait;
    logic bulk_wait;
    rand_wait = 1'b0;
    bulk_wait = 1'b0;
    if (ev_kind[idx] == "refresh")
      refresh_strobe = ~refresh_strobe;
    if (ev_kind[idx] == "rand")
    begin
      rand_address = ev_addr[idx];
      rand_we      = ev_we[idx];
      rand_mask    = ev_mask[idx];
      rand_request = 1'b1;
      rand_wait    = 1'b1;
    end
    if (ev_kind[idx] == "bulk" || ev_kind[idx] == "both")
    begin
      bulk_address = ev_addr[idx];
      bulk_we      = ev_we[idx];
      bulk_mask    = ev_mask[idx];
      bulk_request = 1'b1;
      bulk_wait    = 1'b1;
    end
    if (ev_kind[idx] == "both")
    begin
      rand_address = ev2_addr[idx];
      rand_we      = ev2_we[idx];
      rand_mask    = ev2_mask[idx];
      rand_request = 1'b1;
      rand_wait    = 1'b1;
    end
    // Each port holds its request until its grant
    while (rand_wait || bulk_wait)
    begin
      @(negedge INPUT_CLK);
      if (rand_wait && rand_grant)
      begin
        rand_request = 1'b0;
        rand_wait    = 1'b0;
      end
      if (bulk_wait && bulk_grant)
      begin
        bulk_request = 1'b0;
        bulk_wait    = 1'b0;
      end
    end
  endtask

  // --------------------
  // Monitor
  // --------------------
  always @(negedge INPUT_CLK)
  begin
    expect_t e;
    logic    exp_rand;
    logic    exp_bulk;
    exp_rand = 1'b0;
    exp_bulk = 1'b0;
    if (checking && command_out !== CMD_NOOP)
    begin
      if (exp_q.size() == 0)
      begin
        $display("Command %h came out while no command was expected", command_out);
        errors++;
      end
      else
      begin
        e = exp_q.pop_front();
        check_value("command_out", command_out, e.cmd);
        if (e.cmd != CMD_ARSR)
          check_value("address_out", address_out, e.addr);
        if (e.cmd == CMD_ACTV || e.port != 2'd0)
          check_value("bank_out", bank_out, e.bank);
        if (e.port != 2'd0)
        begin
          held_mask  = e.mask;
          mask_valid = 1'b1;
        end
        exp_rand = (e.port == 2'd1);
        exp_bulk = (e.port == 2'd2);
      end
    end
    if (checking)
    begin
      check_value("rand_grant", rand_grant, exp_rand);
      check_value("bulk_grant", bulk_grant, exp_bulk);
      if (mask_valid)
        check_value("we_mask_out", we_mask_out, held_mask);   // Holds until next access
    end
  end

  initial
  begin
    wait (loaded);
    repeat ((n_tests + 1) * CYCLES_PER_TEST) @(posedge INPUT_CLK);
    $display("Timeout: the tests did not finish in %0d cycles",
             (n_tests + 1) * CYCLES_PER_TEST);
    $display("Something failed");
    $finish;
  end

  initial
  begin
    int          fd;
    int          code;
    int          errors_before;
    int          bad_tests;
    string       kind;
    string       line;
    logic [31:0] t_we;
    logic [31:0] t_addr;
    logic [31:0] t_mask;
    INPUT_CLK      = 1'b0;
    RST            = 1'b0;
    refresh_strobe = 1'b0;
    rand_address   = '0;
    rand_we        = 1'b0;
    rand_request   = 1'b0;
    rand_mask      = '0;
    bulk_address   = '0;
    bulk_we        = 1'b0;
    bulk_request   = 1'b0;
    bulk_mask      = '0;
    model_open     = 1'b0;
    model_page     = '0;
    n_tests        = 0;
    errors         = 0;
    bad_tests      = 0;
    checking       = 1'b0;
    void'($urandom(13));

    fd = $fopen("verification/sdram_cmd_tests.txt", "r");
    if (fd == 0)
    begin
      $display("Could not open the test data file");
      errors++;
    end
    while (fd != 0 && !$feof(fd) && n_tests < MAX_TESTS)
    begin
      code = $fscanf(fd, "%s", kind);
      if (code == 1 && kind.substr(0, 0) == "#")
        code = $fgets(line, fd);   // Column notes
      else if (code == 1)
      begin
        code = $fscanf(fd, "%h %h %h", t_we, t_addr, t_mask);
        ev_kind[n_tests] = kind;
        ev_we[n_tests]   = t_we[0];
        ev_addr[n_tests] = t_addr[`ADDR_W-1:0];
        ev_mask[n_tests] = t_mask[`MASK_W-1:0];
        ev2_addr[n_tests] = '0;
        if (kind == "both")
        begin
          code = $fscanf(fd, "%h %h %h", t_we, t_addr, t_mask);
          ev2_we[n_tests]   = t_we[0];
          ev2_addr[n_tests] = t_addr[`ADDR_W-1:0];
          ev2_mask[n_tests] = t_mask[`MASK_W-1:0];
        end
        n_tests++;
      end
    end
    if (fd != 0)
      $fclose(fd);
    loaded = 1'b1;

    repeat (2) @(negedge INPUT_CLK);
    RST      = 1'b1;
    checking = 1'b1;

    // Monitor expects NOOP and no grants while idle
    repeat (20) @(negedge INPUT_CLK);
    $display("test 0 idle after reset: %s", (errors == 0) ? "ok" : "mismatch");
    if (errors != 0)
      bad_tests++;

    for (int i = 0; i < n_tests; i++)
    begin
      errors_before = errors;
      predict_event(i);
      drive_event(i);
      while (exp_q.size() != 0)
        @(posedge INPUT_CLK);
      @(negedge INPUT_CLK);
      $display("test %0d %s: %s", i + 1, ev_kind[i],
               (errors == errors_before) ? "ok" : "mismatch");
      if (errors != errors_before)
        bad_tests++;
      repeat ($urandom_range(8, 1)) @(negedge INPUT_CLK);
    end

    $display("%0d tests run, %0d with mismatches, %0d check errors",
             n_tests + 1, bad_tests, errors);
    if (errors == 0 && n_tests > 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

endmodule

//--- files.f
+incdir+include
source/sdram_pkg.sv
source/port_req_if.sv
source/port_page_matcher.sv
source/cmd_spacing_timer.sv
source/command_scheduler.sv
source/sdram_cmd_top.sv
verification/tb_sdram_cmd.sv

//--- Makefile
# Verilator build and run for the SDRAM command scheduler testbench

VERILATOR ?= verilator
TOP       ?= tb_sdram_cmd
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= Everything OK

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The run passes only when the pass message shows up in the output
run: compile
	@out="$$($(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- verification/sdram_cmd_tests.txt
# kind we address mask, all fields in hex; refresh lines carry unused zeros
# both: bulk we address mask first, then rand we address mask
rand 0 0012445 3
rand 1 0012510 a
bulk 0 0012003 5
bulk 1 0012007 c
refresh 0 0 0
rand 1 3ffffff f
rand 0 3fffe00 1
rand 0 0abc000 2
both 1 1111234 6 0 2222c01 9
refresh 0 0 0
refresh 0 0 0
both 0 0400200 1 1 0400200 2
both 0 1000000 f 1 0400233 4
refresh 0 0 0
bulk 1 0000000 0
rand 0 00001ff 8
both 0 2000600 3 0 3000800 7
refresh 0 0 0
